//--- msx_mem_params.svh
`ifndef MSX_MEM_PARAMS_SVH
`define MSX_MEM_PARAMS_SVH

// byte lane shared by ioctl, cpu and bram
`define MSX_DATA_W        8

// cpu side address per region
`define MSX_ADDR_W        25

// ioctl download address
`define MSX_IOCTL_AW      27

// bank address widths
`define MSX_BIOS_AW       15   // 32 kB
`define MSX_EXT_AW        14   // 16 kB
`define MSX_DSK_AW        14   // 16 kB
`define MSX_RAM_AW        16   // 64 kB

// bios, ext, disk, ram
`define MSX_NUM_REGIONS   4

// open bus value, seen on missing or out of range reads
`define MSX_FILL_BYTE     8'hFF

// ioctl_index split, low part picks target directly
`define MSX_IDX_LO_W      6
`define MSX_IDX_HI_W      10

`endif

//--- msx_mem_pkg.sv
`include "msx_mem_params.svh"

package msx_mem_pkg;

   // region slot, also the index into mem_req / mem_q
   typedef enum logic [1:0] {
      REGION_BIOS = 2'd0,
      REGION_EXT  = 2'd1,
      REGION_DSK  = 2'd2,
      REGION_RAM  = 2'd3
   } mem_region_e;

   // where an ioctl download lands
   typedef enum logic [1:0] {
      DL_NONE = 2'd0,   // idle or unknown index
      DL_BIOS = 2'd1,
      DL_EXT  = 2'd2,
      DL_DSK  = 2'd3
   } dl_target_e;

   // one cpu access to one region
   typedef struct packed {
      logic [`MSX_ADDR_W-1:0] addr;
      logic [`MSX_DATA_W-1:0] data;   // write data, ram only
      logic                   wren;
      logic                   rden;
   } mem_req_t;

   // download write broadcast to all banks
   typedef struct packed {
      logic [`MSX_IOCTL_AW-1:0] addr;
      logic [`MSX_DATA_W-1:0]   data;
      logic                     wr;     // already range checked
   } dl_wr_t;

endpackage

//--- msx_dl_decode.sv
`timescale 1ns/100ps
`include "msx_mem_params.svh"

module msx_dl_decode (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         ioctl_download,
   input  logic [15:0]                  ioctl_index,
   input  logic                         ioctl_wr,
   input  logic [`MSX_IOCTL_AW-1:0]     ioctl_addr,
   input  logic [`MSX_DATA_W-1:0]       ioctl_dout,
   output msx_mem_pkg::dl_wr_t          dl_wr,
   output logic [`MSX_NUM_REGIONS-1:0]  bank_sel,
   output logic                         reset_req
);

   msx_mem_pkg::dl_target_e        tgt_d;      // decoded this cycle
   msx_mem_pkg::dl_target_e        tgt_q;      // download state
   logic                           addr_fits;
   logic [`MSX_NUM_REGIONS-1:0]    sel_d;
   logic                           wr_q;
   logic [`MSX_IOCTL_AW-1:0]       addr_q;
   logic [`MSX_DATA_W-1:0]         data_q;

   // index decode, only while a download runs
   always_comb begin
      tgt_d = msx_mem_pkg::DL_NONE;
      if (ioctl_download) begin
         case (ioctl_index[`MSX_IDX_LO_W-1:0])
            6'd1: tgt_d = msx_mem_pkg::DL_BIOS;
            6'd2: tgt_d = msx_mem_pkg::DL_EXT;
            6'd3: tgt_d = msx_mem_pkg::DL_DSK;
            6'd0: begin
               // combined image, upper bits name the part
               case (ioctl_index[15:`MSX_IDX_LO_W])
                  10'd0:   tgt_d = msx_mem_pkg::DL_BIOS;
                  10'd1:   tgt_d = msx_mem_pkg::DL_EXT;
                  10'd2:   tgt_d = msx_mem_pkg::DL_DSK;
                  default: tgt_d = msx_mem_pkg::DL_NONE;
               endcase
            end
            default: tgt_d = msx_mem_pkg::DL_NONE;   // rom, fw etc not kept
         endcase
      end
   end

   // drop bytes past the end of the target bank
   always_comb begin
      case (tgt_d)
         msx_mem_pkg::DL_BIOS: addr_fits = (ioctl_addr >> `MSX_BIOS_AW) == '0;
         msx_mem_pkg::DL_EXT:  addr_fits = (ioctl_addr >> `MSX_EXT_AW) == '0;
         msx_mem_pkg::DL_DSK:  addr_fits = (ioctl_addr >> `MSX_DSK_AW) == '0;
         default:              addr_fits = 1'b0;
      endcase
   end

   // one-hot bank pick, ram bit stays clear
   always_comb begin
      sel_d = '0;
      case (tgt_d)
         msx_mem_pkg::DL_BIOS: sel_d[msx_mem_pkg::REGION_BIOS] = 1'b1;
         msx_mem_pkg::DL_EXT:  sel_d[msx_mem_pkg::REGION_EXT]  = 1'b1;
         msx_mem_pkg::DL_DSK:  sel_d[msx_mem_pkg::REGION_DSK]  = 1'b1;
         default:              sel_d = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tgt_q    <= msx_mem_pkg::DL_NONE;
         bank_sel <= '0;
         wr_q     <= 1'b0;
      end else begin
         tgt_q    <= tgt_d;
         bank_sel <= sel_d;
         wr_q     <= ioctl_wr & addr_fits;   // strobe lines up with sel
      end
   end

   // payload follows the strobe
   always_ff @(posedge clk) begin
      addr_q <= ioctl_addr;
      data_q <= ioctl_dout;
   end

   assign dl_wr.addr = addr_q;
   assign dl_wr.data = data_q;
   assign dl_wr.wr   = wr_q;

   // machine held in reset for the whole valid download
   assign reset_req = (tgt_q != msx_mem_pkg::DL_NONE);

endmodule

//--- msx_mem_bank.sv
`timescale 1ns/100ps
`include "msx_mem_params.svh"

module msx_mem_bank #(
   parameter int ADDR_W   = 14,     // bank holds 2**ADDR_W bytes
   parameter bit WRITABLE = 1'b0    // cpu may write, ram only
) (
   input  logic                   clk,
   input  msx_mem_pkg::dl_wr_t    dl_wr,
   input  logic                   dl_sel,
   input  msx_mem_pkg::mem_req_t  req,
   output logic [`MSX_DATA_W-1:0] q,
   output logic                   out_of_range
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [`MSX_DATA_W-1:0] mem [DEPTH];   // single port bram
   logic [ADDR_W-1:0]      addr;
   logic [`MSX_DATA_W-1:0] wdata;
   logic                   cpu_oor;
   logic                   cpu_we;
   logic                   we;

   // any cpu address bit above the bank is a miss
   assign cpu_oor = (req.addr >> ADDR_W) != '0;

   // download owns the port while selected
   assign addr  = dl_sel ? dl_wr.addr[ADDR_W-1:0] : req.addr[ADDR_W-1:0];
   assign wdata = dl_sel ? dl_wr.data : req.data;

   assign cpu_we = WRITABLE & req.wren & ~cpu_oor;   // rom banks ignore wren
   assign we     = dl_sel ? dl_wr.wr : cpu_we;

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      q            <= mem[addr];   // one cycle read, old data on collision
      out_of_range <= cpu_oor;     // flag travels with its data
   end

endmodule

//--- msx_read_mux.sv
`timescale 1ns/100ps
`include "msx_mem_params.svh"

module msx_read_mux (
   input  logic                         clk,
   input  logic                         rst_n,
   input  msx_mem_pkg::mem_req_t        req      [`MSX_NUM_REGIONS],
   input  logic [`MSX_DATA_W-1:0]       bank_q   [`MSX_NUM_REGIONS],
   input  logic [`MSX_NUM_REGIONS-1:0]  bank_oor,
   output logic [`MSX_DATA_W-1:0]       mem_q    [`MSX_NUM_REGIONS]
);

   logic [`MSX_NUM_REGIONS-1:0] rd_vld;   // read issued last cycle

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_vld <= '0;
      end else begin
         for (int i = 0; i < `MSX_NUM_REGIONS; i++) begin
            rd_vld[i] <= req[i].rden;
         end
      end
   end

   // open bus unless a real in-range read is pending
   always_comb begin
      for (int i = 0; i < `MSX_NUM_REGIONS; i++) begin
         if (rd_vld[i] && !bank_oor[i]) begin
            mem_q[i] = bank_q[i];
         end else begin
            mem_q[i] = `MSX_FILL_BYTE;
         end
      end
   end

endmodule

//--- msx_rom_store.sv
`timescale 1ns/100ps
`include "msx_mem_params.svh"

module msx_rom_store (
   input  logic                         clk,
   input  logic                         rst_n,
   // image download
   input  logic                         ioctl_download,
   input  logic [15:0]                  ioctl_index,
   input  logic                         ioctl_wr,
   input  logic [`MSX_IOCTL_AW-1:0]     ioctl_addr,
   input  logic [`MSX_DATA_W-1:0]       ioctl_dout,
   // cpu regions, indexed by mem_region_e
   input  msx_mem_pkg::mem_req_t        mem_req [`MSX_NUM_REGIONS],
   output logic [`MSX_DATA_W-1:0]       mem_q   [`MSX_NUM_REGIONS],
   output logic                         reset_req
);

   msx_mem_pkg::dl_wr_t            dl_wr;      // shared by every bank
   logic [`MSX_NUM_REGIONS-1:0]    bank_sel;
   logic [`MSX_DATA_W-1:0]         bank_q [`MSX_NUM_REGIONS];
   logic [`MSX_NUM_REGIONS-1:0]    bank_oor;

   msx_dl_decode u_dl_decode (
      .clk            (clk),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .dl_wr          (dl_wr),
      .bank_sel       (bank_sel),
      .reset_req      (reset_req)
   );

   generate
      for (genvar i = 0; i < `MSX_NUM_REGIONS; i++) begin : g_bank
         // size by region slot
         localparam int AW = (i == msx_mem_pkg::REGION_BIOS) ? `MSX_BIOS_AW :
                             (i == msx_mem_pkg::REGION_EXT)  ? `MSX_EXT_AW  :
                             (i == msx_mem_pkg::REGION_DSK)  ? `MSX_DSK_AW  :
                                                               `MSX_RAM_AW;
         localparam bit WR = (i == msx_mem_pkg::REGION_RAM);   // only ram is rw

         msx_mem_bank #(
            .ADDR_W   (AW),
            .WRITABLE (WR)
         ) u_bank (
            .clk          (clk),
            .dl_wr        (dl_wr),
            .dl_sel       (bank_sel[i]),
            .req          (mem_req[i]),
            .q            (bank_q[i]),
            .out_of_range (bank_oor[i])
         );
      end
   endgenerate

   msx_read_mux u_read_mux (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (mem_req),
      .bank_q   (bank_q),
      .bank_oor (bank_oor),
      .mem_q    (mem_q)
   );

endmodule

//--- msx_rom_store_checker.sv
`timescale 1ns/100ps
`include "msx_mem_params.svh"

module msx_rom_store_checker (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         ioctl_download,
   input  logic [15:0]                  ioctl_index,
   input  logic                         ioctl_wr,
   input  logic [`MSX_IOCTL_AW-1:0]     ioctl_addr,
   input  logic [`MSX_DATA_W-1:0]       ioctl_dout,
   input  msx_mem_pkg::mem_req_t        mem_req [`MSX_NUM_REGIONS],
   input  logic [`MSX_DATA_W-1:0]       mem_q   [`MSX_NUM_REGIONS],
   input  logic                         reset_req
);

   // model of every bank, sized for the largest one
   logic [`MSX_DATA_W-1:0] shadow   [`MSX_NUM_REGIONS][1 << `MSX_RAM_AW];
   logic [`MSX_DATA_W-1:0] exp_q    [`MSX_NUM_REGIONS];
   logic [`MSX_ADDR_W-1:0] exp_addr [`MSX_NUM_REGIONS];
   logic                   exp_rr;
   logic                   armed;       // first edge seen
   logic                   pend_wr;     // download byte in flight
   int                     pend_reg;
   int                     pend_addr;
   logic [`MSX_DATA_W-1:0] pend_data;
   int                     error_count;
   int                     check_count;
   int                     test_count;
   int                     test_errors;

   initial begin
      armed       = 1'b0;
      pend_wr     = 1'b0;
      exp_rr      = 1'b0;
      error_count = 0;
      check_count = 0;
      test_count  = 0;
      test_errors = 0;
   end

   function automatic int region_width(input int region);
      case (region)
         0:       return `MSX_BIOS_AW;   // 32 kB
         1:       return `MSX_EXT_AW;
         2:       return `MSX_DSK_AW;
         default: return `MSX_RAM_AW;    // 64 kB
      endcase
   endfunction

   // -1 when the image is not kept
   function automatic int target_region(input logic [15:0] index);
      logic [5:0] lo;
      logic [9:0] hi;
      lo = index[5:0];
      hi = index[15:6];
      if (lo == 6'd1) return 0;
      if (lo == 6'd2) return 1;
      if (lo == 6'd3) return 2;
      if (lo == 6'd0 && hi <= 10'd2) return int'(hi);   // combined image
      return -1;
   endfunction

   // reference model of one cpu read
   function automatic logic [7:0] expected_byte(input int region,
                                                input logic [`MSX_ADDR_W-1:0] addr,
                                                input logic rd);
      int aw;
      aw = region_width(region);
      if (!rd || (addr >> aw) != 0) return `MSX_FILL_BYTE;
      return shadow[region][addr & ((1 << aw) - 1)];
   endfunction

   always @(posedge clk) begin : model
      int r;
      // data due after this edge, old contents on a same cycle write
      for (int i = 0; i < `MSX_NUM_REGIONS; i++) begin
         exp_q[i]    = expected_byte(i, mem_req[i].addr, mem_req[i].rden & rst_n);
         exp_addr[i] = mem_req[i].addr;
      end
      r      = target_region(ioctl_index);
      exp_rr = rst_n && ioctl_download && (r >= 0);
      if (pend_wr) begin
         shadow[pend_reg][pend_addr] = pend_data;   // one edge behind ioctl_wr
      end
      pend_wr = 1'b0;
      if (rst_n && ioctl_download && ioctl_wr && r >= 0) begin
         if ((ioctl_addr >> region_width(r)) == 0) begin
            pend_wr   = 1'b1;
            pend_reg  = r;
            pend_addr = ioctl_addr;
            pend_data = ioctl_dout;
         end
      end
      // cpu writes reach ram only
      if (mem_req[3].wren && (mem_req[3].addr >> `MSX_RAM_AW) == 0) begin
         shadow[3][mem_req[3].addr[`MSX_RAM_AW-1:0]] = mem_req[3].data;
      end
      armed = 1'b1;
   end

   // compare half a cycle later, outputs settled
   always @(negedge clk) begin
      if (armed) begin
         for (int i = 0; i < `MSX_NUM_REGIONS; i++) begin
            check_count++;
            if (mem_q[i] !== exp_q[i]) begin
               error_count++;
               test_errors++;
               $display("FAILED %0t: region %0d addr %h read %h, expected %h",
                        $time, i, exp_addr[i], mem_q[i], exp_q[i]);
            end
         end
         check_count++;
         if (reset_req !== exp_rr) begin
            error_count++;
            test_errors++;
            $display("FAILED %0t: reset_req is %b, expected %b", $time, reset_req, exp_rr);
         end
      end
   end

   task end_test(input string name);
      test_count++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", test_count, name);
      end else begin
         $display("test %0d %s: %0d errors", test_count, name, test_errors);
      end
      test_errors = 0;
   endtask

   task report_totals;
      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
   endtask

endmodule

//--- msx_rom_store_tb.sv
`timescale 1ns/100ps
`include "msx_mem_params.svh"

module msx_rom_store_tb;

   logic                          clk;
   logic                          rst_n;
   logic                          ioctl_download;
   logic [15:0]                   ioctl_index;
   logic                          ioctl_wr;
   logic [`MSX_IOCTL_AW-1:0]      ioctl_addr;
   logic [`MSX_DATA_W-1:0]        ioctl_dout;
   msx_mem_pkg::mem_req_t         mem_req [`MSX_NUM_REGIONS];
   logic [`MSX_DATA_W-1:0]        mem_q   [`MSX_NUM_REGIONS];
   logic                          reset_req;
   logic [31:0]                   lfsr;      // random source state
   int                            timeouts;  // waits that gave up

   msx_rom_store uut (
      .clk            (clk),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .mem_req        (mem_req),
      .mem_q          (mem_q),
      .reset_req      (reset_req)
   );

   msx_rom_store_checker chk (
      .clk            (clk),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .mem_req        (mem_req),
      .mem_q          (mem_q),
      .reset_req      (reset_req)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // galois lfsr shifting right with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task step_clock;
      @(posedge clk);
      #1;   // inputs change just after the edge
   endtask

   task clear_requests;
      for (int i = 0; i < `MSX_NUM_REGIONS; i++) begin
         mem_req[i] = '0;
      end
   endtask

   // stream random bytes through ioctl
   task download_bytes(input logic [15:0] index, input int base, input int count);
      ioctl_download = 1'b1;
      ioctl_index    = index;
      for (int k = 0; k < count; k++) begin
         ioctl_wr   = 1'b1;
         ioctl_addr = base + k;
         ioctl_dout = rand_bits(8);
         step_clock();
      end
      ioctl_wr = 1'b0;
      step_clock();            // last byte lands while the bank is still selected
      ioctl_download = 1'b0;
      step_clock();
   endtask

   // back to back reads at one per cycle
   task read_bytes(input int region, input int base, input int count);
      for (int k = 0; k < count; k++) begin
         mem_req[region].addr = base + k;
         mem_req[region].wren = 1'b0;
         mem_req[region].rden = 1'b1;
         step_clock();
      end
      mem_req[region].rden = 1'b0;
      step_clock();   // last data seen by the checker here
   endtask

   task write_byte(input int region, input int addr, input logic [7:0] data);
      mem_req[region].addr = addr;
      mem_req[region].data = data;
      mem_req[region].wren = 1'b1;
      mem_req[region].rden = 1'b0;
      step_clock();
      mem_req[region].wren = 1'b0;
   endtask

   task wait_reset_req(input logic level);
      int n;
      n = 0;
      while (reset_req !== level && n < 10) begin
         step_clock();
         n++;
      end
      if (reset_req !== level) begin
         $display("timeout waiting for reset_req to go to %0b", level);
         timeouts++;
      end
   endtask

   initial begin
      int a;
      lfsr           = 32'h6eab_6305;
      timeouts       = 0;
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_wr       = 1'b0;
      ioctl_addr     = '0;
      ioctl_dout     = '0;
      clear_requests();
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      step_clock();

      download_bytes(16'd1, 0, 64);
      download_bytes(16'd1, 32752, 16);   // top of bios
      download_bytes(16'd2, 0, 64);
      download_bytes(16'd3, 0, 64);
      read_bytes(0, 0, 64);
      read_bytes(0, 32752, 16);
      read_bytes(1, 0, 64);
      read_bytes(2, 0, 64);
      chk.end_test("download by index 1 2 3");

      download_bytes(16'h0000, 128, 32);   // upper bits 0 pick bios
      download_bytes(16'h0040, 128, 32);   // upper bits 1 pick ext
      download_bytes(16'h0080, 128, 32);   // upper bits 2 pick disk
      download_bytes(16'd5, 0, 64);        // not stored
      download_bytes(16'h00C0, 0, 64);     // upper bits 3 go nowhere
      for (int r = 0; r < 3; r++) begin
         read_bytes(r, 0, 64);
         read_bytes(r, 128, 32);
      end
      chk.end_test("download by index 0 and unknown index");

      download_bytes(16'd1, 32768, 32);
      download_bytes(16'd2, 16384, 32);
      download_bytes(16'd3, 1 << 26, 32);
      for (int r = 0; r < 3; r++) begin
         read_bytes(r, 0, 32);
      end
      chk.end_test("download past bank end");

      for (int k = 0; k < 48; k++) begin
         a = rand_bits(16);
         write_byte(3, a, rand_bits(8));
         read_bytes(3, a, 1);              // read right behind the write
      end
      for (int k = 0; k < 32; k++) begin
         write_byte(3, 16'h8000 + k, rand_bits(8));
      end
      read_bytes(3, 16'h8000, 32);
      write_byte(0, 4, 8'h5a);             // bios ignores cpu writes
      read_bytes(0, 0, 8);
      chk.end_test("ram write and read");

      write_byte(3, 0, 8'hc3);
      write_byte(3, 1 << 16, 8'h33);       // must not alias to 0
      read_bytes(3, 0, 1);
      read_bytes(0, 1 << 15, 2);
      read_bytes(1, 1 << 14, 2);
      read_bytes(2, 1 << 14, 2);
      read_bytes(3, 1 << 16, 2);
      for (int r = 0; r < `MSX_NUM_REGIONS; r++) begin
         read_bytes(r, 25'h1FF_FFFF, 1);
         mem_req[r].addr = 2;              // idle cycle with rden low
         step_clock();
      end
      chk.end_test("out of range and idle reads");

      ioctl_index    = 16'd2;
      ioctl_download = 1'b1;
      wait_reset_req(1'b1);
      repeat (3) step_clock();
      ioctl_download = 1'b0;
      wait_reset_req(1'b0);
      ioctl_index    = 16'd7;              // no target so reset_req stays low
      ioctl_download = 1'b1;
      repeat (4) step_clock();
      ioctl_download = 1'b0;
      step_clock();
      chk.end_test("reset request");

      chk.report_totals();
      if (chk.error_count == 0 && timeouts == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- msx_rom_store.f
+incdir+.
msx_mem_pkg.sv
msx_dl_decode.sv
msx_mem_bank.sv
msx_read_mux.sv
msx_rom_store.sv
msx_rom_store_checker.sv
msx_rom_store_tb.sv

//--- Bender.yml
package:
  name: msx_rom_store

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - msx_mem_pkg.sv
      - msx_dl_decode.sv
      - msx_mem_bank.sv
      - msx_read_mux.sv
      - msx_rom_store.sv
  - target: test
    include_dirs:
      - .
    files:
      - msx_rom_store_checker.sv
      - msx_rom_store_tb.sv
